/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_soc_io \
    -o tb_soc_io > build.log 2>&1 \
    && ./obj_dir/tb_soc_io > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* tb/tb_soc_io.sv */
`include "soc_io_config.svh"

module tb_soc_io;

    logic clk, rst, dev_strobe_i, dev_we_i, uart_ready_i, eth_ready_i;
    logic [31:0] dev_addr_i, dev_din_i, dev_dout_o, uart_dout_i, eth_dout_i, rdata_i;
    logic [31:0] wdata_o;
    logic [3:0] dev_be_i, wstrb_o;
    logic [1:0] uart_idx_o;
    logic [6:0] awaddr_o, araddr_o;
    logic dev_ready_o, io_rst_o, uart_en_o, eth_strobe_o;
    logic awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i, bready_o;
    logic arvalid_o, arready_i, rvalid_i, rready_o;

    logic [31:0] seed = 32'hcc10_924a;
    logic [31:0] slave_mem [0:31];   // AXI slave register file
    logic [31:0] exp_addr, exp_data, exp_rdata, w_data_q;
    logic [3:0]  exp_be, w_strb_q;
    logic [6:0]  aw_addr_q, ar_addr_q;
    logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
    logic chk_rd, spi_wr_phase, unmapped_phase;
    int errs, tests;
    int cycles = 0;
    int rst_age = 15;   // Saturated until rst is first seen

    soc_io_top dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int stall_len();
        return int'(lcg() % 32'd4);   // 0 to 3 cycles
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp, got);
        $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
        errs++;
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("Test %s done, %0d errors", name, errs - start);
    endtask

    // ----------------------------------------
    // Handshake capture at the rising edge
    // ----------------------------------------
    always @(posedge clk)
    begin
        aw_hs <= awvalid_o && awready_i;
        w_hs  <= wvalid_o && wready_i;
        ar_hs <= arvalid_o && arready_i;
        b_hs  <= bvalid_i && bready_o;
        r_hs  <= rvalid_i && rready_o;
        if (awvalid_o && awready_i) aw_addr_q <= awaddr_o;
        if (arvalid_o && arready_i) ar_addr_q <= araddr_o;
        if (wvalid_o && wready_i)
        begin
            w_data_q <= wdata_o;
            w_strb_q <= wstrb_o;
        end
        rst_age <= rst ? 0 : (rst_age < 15 ? rst_age + 1 : rst_age);   // Edges since rst
        cycles  <= cycles + 1;
        if (cycles >= 2000)
        begin
            $display("Timeout: no completion within 2000 cycles");
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_rst_hold: assert property (@(posedge clk) rst_age <= 8 |-> io_rst_o)
        else report_mismatch("io_rst_o", 1, 32'($sampled(io_rst_o)));
    a_rst_fall: assert property (@(posedge clk) rst_age == 9 |-> !io_rst_o)
        else report_mismatch("io_rst_o", 0, 32'($sampled(io_rst_o)));
    a_rst_idle: assert property (@(posedge clk) rst_age == 9 |->
        !(awvalid_o | wvalid_o | arvalid_o | bready_o | rready_o))
        else report_mismatch("axi valids", 0, 1);
    a_aw_hold: assert property (@(posedge clk) disable iff (io_rst_o)
        awvalid_o && !awready_i |=> awvalid_o) else report_mismatch("awvalid_o", 1, 0);
    a_w_hold: assert property (@(posedge clk) disable iff (io_rst_o)
        wvalid_o && !wready_i |=> wvalid_o) else report_mismatch("wvalid_o", 1, 0);
    a_ar_hold: assert property (@(posedge clk) disable iff (io_rst_o)
        arvalid_o && !arready_i |=> arvalid_o) else report_mismatch("arvalid_o", 1, 0);
    a_awaddr: assert property (@(posedge clk) disable iff (io_rst_o)
        awvalid_o |-> awaddr_o == exp_addr[6:0])
        else report_mismatch("awaddr_o", 32'(exp_addr[6:0]), 32'($sampled(awaddr_o)));
    a_araddr: assert property (@(posedge clk) disable iff (io_rst_o)
        arvalid_o |-> araddr_o == exp_addr[6:0])
        else report_mismatch("araddr_o", 32'(exp_addr[6:0]), 32'($sampled(araddr_o)));
    a_wdata: assert property (@(posedge clk) disable iff (io_rst_o)
        wvalid_o |-> wdata_o == exp_data)
        else report_mismatch("wdata_o", exp_data, $sampled(wdata_o));
    a_wstrb: assert property (@(posedge clk) disable iff (io_rst_o)
        wvalid_o |-> wstrb_o == exp_be)
        else report_mismatch("wstrb_o", 32'(exp_be), 32'($sampled(wstrb_o)));
    a_rready_one: assert property (@(posedge clk) disable iff (io_rst_o)
        rready_o |=> !rready_o) else report_mismatch("rready_o", 0, 1);
    a_rready_ans: assert property (@(posedge clk) disable iff (io_rst_o)
        rvalid_i && !rready_o |=> rready_o) else report_mismatch("rready_o", 1, 0);
    a_ready_pulse: assert property (@(posedge clk) disable iff (io_rst_o)
        dev_ready_o |=> !dev_ready_o) else report_mismatch("dev_ready_o", 0, 1);
    a_wr_after_b: assert property (@(posedge clk) disable iff (io_rst_o)
        dev_ready_o && spi_wr_phase |-> $past(bready_o)) else report_mismatch("bready_o", 1, 0);
    a_rd_data: assert property (@(posedge clk) disable iff (io_rst_o)
        dev_ready_o && chk_rd |-> dev_dout_o == exp_rdata)
        else report_mismatch("dev_dout_o", exp_rdata, $sampled(dev_dout_o));
    a_uart_sel: assert property (@(posedge clk) disable iff (io_rst_o)
        dev_strobe_i && dev_addr_i[31:24] == 8'hC0 |-> uart_en_o && !eth_strobe_o &&
        uart_idx_o == dev_addr_i[3:2])
        else report_mismatch("uart_en_o", 1, 32'($sampled(uart_en_o)));
    a_eth_sel: assert property (@(posedge clk) disable iff (io_rst_o)
        dev_strobe_i && dev_addr_i[31:24] == 8'hC3 |-> eth_strobe_o && !uart_en_o)
        else report_mismatch("eth_strobe_o", 1, 32'($sampled(eth_strobe_o)));
    a_no_axi: assert property (@(posedge clk) disable iff (io_rst_o)
        uart_en_o || eth_strobe_o |=> !awvalid_o && !arvalid_o)
        else report_mismatch("awvalid_o", 0, 1);
    a_unmapped: assert property (@(posedge clk) disable iff (io_rst_o)
        unmapped_phase |-> !uart_en_o && !eth_strobe_o && !awvalid_o && !arvalid_o &&
        !dev_ready_o && dev_dout_o == 32'd0)
        else report_mismatch("dev_dout_o", 0, $sampled(dev_dout_o));

    // ----------------------------------------
    // CPU bus and device models
    // ----------------------------------------
    task automatic cpu_strobe(input logic [31:0] addr, data, input logic we, input logic [3:0] be);
        @(negedge clk);
        exp_addr     = addr;
        exp_data     = data;
        exp_be       = be;
        dev_addr_i   = addr;
        dev_din_i    = data;
        dev_we_i     = we;
        dev_be_i     = be;
        dev_strobe_i = 1'b1;
        @(negedge clk);
        dev_strobe_i = 1'b0;   // One-cycle pulse
    endtask

    task automatic spi_write(input logic [31:0] addr, data, input logic [3:0] be);
        logic [31:0] merged;
        merged = slave_mem[addr[6:2]];
        for (int b = 0; b < 4; b++)
            if (be[b]) merged[8*b +: 8] = data[8*b +: 8];
        spi_wr_phase = 1'b1;
        cpu_strobe(addr, data, 1'b1, be);
        fork
            begin
                repeat (stall_len()) @(negedge clk);
                awready_i = 1'b1;
                do @(negedge clk); while (!aw_hs);
                awready_i = 1'b0;
            end
            begin
                repeat (stall_len()) @(negedge clk);
                wready_i = 1'b1;
                do @(negedge clk); while (!w_hs);
                wready_i = 1'b0;
            end
        join
        for (int b = 0; b < 4; b++)
            if (w_strb_q[b]) slave_mem[aw_addr_q[6:2]][8*b +: 8] = w_data_q[8*b +: 8];
        repeat (stall_len()) @(negedge clk);
        bvalid_i = 1'b1;
        do @(negedge clk); while (!b_hs);
        bvalid_i = 1'b0;
        while (!dev_ready_o) @(negedge clk);
        @(negedge clk);
        spi_wr_phase = 1'b0;
        a_slave_word: assert (slave_mem[addr[6:2]] === merged)
            else report_mismatch("slave word", merged, slave_mem[addr[6:2]]);
    endtask

    task automatic spi_read(input logic [31:0] addr);
        exp_rdata = slave_mem[addr[6:2]];
        chk_rd    = 1'b1;
        cpu_strobe(addr, 32'd0, 1'b0, 4'h0);
        repeat (stall_len()) @(negedge clk);
        arready_i = 1'b1;
        do @(negedge clk); while (!ar_hs);
        arready_i = 1'b0;
        repeat (stall_len()) @(negedge clk);
        rvalid_i = 1'b1;
        rdata_i  = slave_mem[ar_addr_q[6:2]];
        do @(negedge clk); while (!r_hs);
        rvalid_i = 1'b0;
        rdata_i  = lcg();    // Junk once the beat is gone
        while (!dev_ready_o) @(negedge clk);
        @(negedge clk);
        chk_rd = 1'b0;
    endtask

    // UART answers with its word index, Ethernet with its address
    task automatic device_access(input logic [31:0] addr);
        exp_rdata = (addr[31:24] == 8'hC0) ? 32'h0A00_0000 | 32'(addr[3:2]) * 32'h11
                                           : addr ^ 32'hE7E7_5A5A;
        chk_rd = 1'b1;
        cpu_strobe(addr, 32'd0, 1'b0, 4'h0);
        repeat (stall_len()) @(negedge clk);
        if (addr[31:24] == 8'hC0)
        begin
            uart_dout_i  = 32'h0A00_0000 | 32'(uart_idx_o) * 32'h11;
            uart_ready_i = 1'b1;
        end
        else
        begin
            eth_dout_i  = dev_addr_i ^ 32'hE7E7_5A5A;
            eth_ready_i = 1'b1;
        end
        @(negedge clk);
        uart_ready_i = 1'b0;
        eth_ready_i  = 1'b0;
        chk_rd       = 1'b0;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        int start;
        logic [31:0] a;
        logic [31:0] b;
        rst            = 1'b1;
        dev_strobe_i   = 1'b0;
        dev_addr_i     = '0;
        dev_we_i       = 1'b0;
        dev_be_i       = '0;
        dev_din_i      = '0;
        uart_dout_i    = '0;
        uart_ready_i   = 1'b0;
        eth_dout_i     = '0;
        eth_ready_i    = 1'b0;
        awready_i      = 1'b0;
        wready_i       = 1'b0;
        bvalid_i       = 1'b0;
        arready_i      = 1'b0;
        rdata_i        = '0;
        rvalid_i       = 1'b0;
        chk_rd         = 1'b0;
        spi_wr_phase   = 1'b0;
        unmapped_phase = 1'b0;
        errs           = 0;
        tests          = 0;
        for (int i = 0; i < 32; i++)
            slave_mem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0101_0101);   // Whole index
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        start = errs;
        while (io_rst_o) @(negedge clk);
        repeat (2) @(negedge clk);
        finish_test("reset_stretch", start);

        start = errs;
        for (int i = 0; i < 8; i++)
        begin
            a = lcg();
            b = lcg();
            spi_write({8'hC2, a[24:7], 4'(i), 2'b00}, lcg(), b[3:0]);
        end
        finish_test("spi_write", start);

        start = errs;
        for (int i = 0; i < 8; i++)
        begin
            a = lcg();
            spi_read({8'hC2, a[24:7], 4'(7 - i), 2'b00});
        end
        finish_test("spi_read", start);

        start = errs;
        for (int i = 0; i < 8; i++)
        begin
            a = lcg();
            device_access({i[0] ? 8'hC3 : 8'hC0, a[23:0]});
        end
        finish_test("uart_eth_routing", start);

        start = errs;
        for (int i = 0; i < 2; i++)
        begin
            a = lcg();
            b = {8'h10 + 8'(i) * 8'h40, a[23:0]};
            @(negedge clk);
            dev_addr_i     = b;      // Off-map address before the strobe
            unmapped_phase = 1'b1;
            cpu_strobe(b, a, i[0], 4'hF);
            repeat (20) @(negedge clk);
            unmapped_phase = 1'b0;
        end
        finish_test("unmapped", start);

        $display("Tests run %0d, errors %0d", tests, errs);
        if (errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/soc_io_pkg.sv
verilog/io_reset_stretch.sv
verilog/axi_wr_master.sv
verilog/axi_rd_master.sv
verilog/io_bus_decode.sv
verilog/soc_io_top.sv
tb/tb_soc_io.sv

/* verilog/axi_rd_master.sv */
`include "soc_io_config.svh"

module axi_rd_master (
    input  logic                    clk,
    input  logic                    io_rst_i,
    input  logic                    rd_req_i,    // One-cycle SPI read pulse
    input  soc_io_pkg::dev_addr_u   addr_i,
    output logic [`SOC_AXI_AW-1:0]  araddr_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  logic [`SOC_XLEN-1:0]    rdata_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,
    output logic [`SOC_XLEN-1:0]    rd_word_o,   // Last word seen on rdata
    output logic                    rd_done_o    // Read finished, one cycle
);

    // ----------------------------------------
    // Read address channel
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
            arvalid_o <= 1'b0;
        else if (rd_req_i)
            arvalid_o <= 1'b1;
        else if (arready_i)
            arvalid_o <= 1'b0;    // Address accepted
    end

    always_ff @(posedge clk)
    begin
        if (rd_req_i)
            araddr_o <= addr_i.regv.reg_off;   // Held while arvalid waits
    end

    // ----------------------------------------
    // Read data channel
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
        begin
            rready_o  <= 1'b0;
            rd_done_o <= 1'b0;
        end
        else
        begin
            rready_o  <= rvalid_i & ~rready_o;   // Pulse once per rvalid
            rd_done_o <= rvalid_i & rready_o;    // One cycle after handshake
        end
    end

    // Capture on every valid beat, last one wins
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
            rd_word_o <= '0;
        else if (rvalid_i)
            rd_word_o <= rdata_i;
    end

endmodule

/* verilog/axi_wr_master.sv */
`include "soc_io_config.svh"

module axi_wr_master (
    input  logic                    clk,
    input  logic                    io_rst_i,
    input  logic                    wr_req_i,    // One-cycle SPI write pulse
    input  soc_io_pkg::dev_addr_u   addr_i,      // Held by the CPU until ready
    output logic [`SOC_AXI_AW-1:0]  awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o,
    output logic                    wr_done_o    // Write finished, one cycle
);

    // ----------------------------------------
    // Write address channel
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
            awvalid_o <= 1'b0;
        else if (wr_req_i)
            awvalid_o <= 1'b1;
        else if (awready_i)
            awvalid_o <= 1'b0;    // Slave took the address
    end

    // Register offset only, no reset on the address
    always_ff @(posedge clk)
    begin
        if (wr_req_i)
            awaddr_o <= addr_i.regv.reg_off;
    end

    // ----------------------------------------
    // Write data channel
    // ----------------------------------------
    // Data and strobes come straight off the CPU bus
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
            wvalid_o <= 1'b0;
        else if (wr_req_i)
            wvalid_o <= 1'b1;
        else if (wready_i)
            wvalid_o <= 1'b0;     // Independent of the address channel
    end

    // ----------------------------------------
    // Write response channel
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (io_rst_i)
        begin
            bready_o  <= 1'b0;
            wr_done_o <= 1'b0;
        end
        else
        begin
            bready_o  <= bvalid_i & ~bready_o;   // Single-cycle acknowledge
            wr_done_o <= bvalid_i & bready_o;    // Completion right after handshake
        end
    end

endmodule

/* verilog/io_bus_decode.sv */
`include "soc_io_config.svh"

module io_bus_decode (
    input  logic                    dev_strobe_i,
    input  soc_io_pkg::dev_addr_u   dev_addr_i,
    input  logic                    dev_we_i,
    output logic                    spi_wr_req_o,
    output logic                    spi_rd_req_o,
    input  logic                    wr_done_i,
    input  logic                    rd_done_i,
    input  logic [`SOC_XLEN-1:0]    rd_word_i,
    output logic                    uart_en_o,
    output logic [1:0]              uart_idx_o,
    input  logic [`SOC_XLEN-1:0]    uart_dout_i,
    input  logic                    uart_ready_i,
    output logic                    eth_strobe_o,
    input  logic [`SOC_XLEN-1:0]    eth_dout_i,
    input  logic                    eth_ready_i,
    output logic [`SOC_XLEN-1:0]    dev_dout_o,
    output logic                    dev_ready_o
);

    logic uart_sel;
    logic spi_sel;
    logic eth_sel;
    logic spi_ready;

    // Region match on the top address byte
    assign uart_sel = (dev_addr_i.rgn.region == `SOC_REGION_UART);
    assign spi_sel  = (dev_addr_i.rgn.region == `SOC_REGION_SPI);
    assign eth_sel  = (dev_addr_i.rgn.region == `SOC_REGION_ETH);

    // Per-region strobes, same cycle as the CPU strobe
    assign uart_en_o    = dev_strobe_i & uart_sel;
    assign uart_idx_o   = dev_addr_i.regv.reg_off[3:2];   // UART word index
    assign eth_strobe_o = dev_strobe_i & eth_sel;
    assign spi_wr_req_o = dev_strobe_i & spi_sel & dev_we_i;
    assign spi_rd_req_o = dev_strobe_i & spi_sel & ~dev_we_i;

    // Either master finishing readies the SPI region
    assign spi_ready = wr_done_i | rd_done_i;

    // Fixed priority UART, SPI, Ethernet
    always_comb
    begin
        if (uart_sel)
        begin
            dev_dout_o  = uart_dout_i;
            dev_ready_o = uart_ready_i;
        end
        else if (spi_sel)
        begin
            dev_dout_o  = rd_word_i;
            dev_ready_o = spi_ready;
        end
        else if (eth_sel)
        begin
            dev_dout_o  = eth_dout_i;
            dev_ready_o = eth_ready_i;
        end
        else
        begin
            dev_dout_o  = '0;      // Unmapped, CPU waits forever
            dev_ready_o = 1'b0;
        end
    end

endmodule

/* verilog/io_reset_stretch.sv */
`include "soc_io_config.svh"

module io_reset_stretch (
    input  logic clk,
    input  logic rst,       // Raw reset
    output logic io_rst_o   // Lengthened reset for the I/O logic
);

    logic [7:0] stretch_cnt;   // Cycles of reset still to go

    // Reload while raw reset is high, then drain to zero
    always_ff @(posedge clk)
    begin
        if (rst)
            stretch_cnt <= 8'(`SOC_RST_STRETCH);
        else if (stretch_cnt != 8'd0)
            stretch_cnt <= stretch_cnt - 8'd1;
    end

    // Registered so downstream logic sees a clean level
    always_ff @(posedge clk)
    begin
        if (rst)
            io_rst_o <= 1'b1;
        else
            io_rst_o <= |stretch_cnt;   // Drops one edge after count hits zero
    end

endmodule

/* verilog/soc_io_config.svh */
`ifndef SOC_IO_CONFIG_SVH
`define SOC_IO_CONFIG_SVH

// ----------------------------------------
// Device bus
// ----------------------------------------
`define SOC_XLEN          32       // Data and address width

// Top address byte of each device region
`define SOC_REGION_UART   8'hC0
`define SOC_REGION_SPI    8'hC2
`define SOC_REGION_ETH    8'hC3

// ----------------------------------------
// SPI controller and reset
// ----------------------------------------
`define SOC_AXI_AW        7        // AXI-Lite register address width
`define SOC_RST_STRETCH   8        // Extra cycles of core reset

`endif

/* verilog/soc_io_pkg.sv */
`include "soc_io_config.svh"

package soc_io_pkg;

    // ----------------------------------------
    // Device address, two views of one word
    // ----------------------------------------

    // Region view for the address decoder
    typedef struct packed {
        logic [7:0]             region;   // Top byte selects the device
        logic [`SOC_XLEN-9:0]   offset;   // Offset inside the region
    } dev_region_t;

    // Register view for the AXI-Lite side
    typedef struct packed {
        logic [`SOC_XLEN-`SOC_AXI_AW-1:0] unused;   // Ignored by the SPI core
        logic [`SOC_AXI_AW-1:0]           reg_off;  // AXI address, UART index in 3:2
    } dev_reg_t;

    // Same 32 bits decoded by region or by register
    typedef union packed {
        dev_region_t rgn;
        dev_reg_t    regv;
    } dev_addr_u;

endpackage

/* verilog/soc_io_top.sv */
`include "soc_io_config.svh"

module soc_io_top (
    input  logic                      clk,
    input  logic                      rst,
    // CPU device bus
    input  logic                      dev_strobe_i,
    input  soc_io_pkg::dev_addr_u     dev_addr_i,
    input  logic                      dev_we_i,
    input  logic [`SOC_XLEN/8-1:0]    dev_be_i,
    input  logic [`SOC_XLEN-1:0]      dev_din_i,
    output logic [`SOC_XLEN-1:0]      dev_dout_o,
    output logic                      dev_ready_o,
    output logic                      io_rst_o,
    // UART core
    output logic                      uart_en_o,
    output logic [1:0]                uart_idx_o,
    input  logic [`SOC_XLEN-1:0]      uart_dout_i,
    input  logic                      uart_ready_i,
    // Ethernet MAC
    output logic                      eth_strobe_o,
    input  logic [`SOC_XLEN-1:0]      eth_dout_i,
    input  logic                      eth_ready_i,
    // AXI-Lite toward the SPI controller
    output logic [`SOC_AXI_AW-1:0]    awaddr_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,
    output logic [`SOC_XLEN-1:0]      wdata_o,
    output logic [`SOC_XLEN/8-1:0]    wstrb_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    output logic                      bready_o,
    output logic [`SOC_AXI_AW-1:0]    araddr_o,
    output logic                      arvalid_o,
    input  logic                      arready_i,
    input  logic [`SOC_XLEN-1:0]      rdata_i,
    input  logic                      rvalid_i,
    output logic                      rready_o
);

    logic                 spi_wr_req;
    logic                 spi_rd_req;
    logic                 wr_done;
    logic                 rd_done;
    logic [`SOC_XLEN-1:0] rd_word;

    assign wdata_o = dev_din_i;   // CPU holds these until ready
    assign wstrb_o = dev_be_i;

    io_reset_stretch u_rst (.clk(clk), .rst(rst), .io_rst_o(io_rst_o));

    // ----------------------------------------
    // Address decode and read mux
    // ----------------------------------------
    io_bus_decode u_decode (
        .dev_strobe_i (dev_strobe_i), .dev_addr_i  (dev_addr_i),  .dev_we_i    (dev_we_i),
        .spi_wr_req_o (spi_wr_req),   .spi_rd_req_o(spi_rd_req),
        .wr_done_i    (wr_done),      .rd_done_i   (rd_done),     .rd_word_i   (rd_word),
        .uart_en_o    (uart_en_o),    .uart_idx_o  (uart_idx_o),
        .uart_dout_i  (uart_dout_i),  .uart_ready_i(uart_ready_i),
        .eth_strobe_o (eth_strobe_o), .eth_dout_i  (eth_dout_i),  .eth_ready_i (eth_ready_i),
        .dev_dout_o   (dev_dout_o),   .dev_ready_o (dev_ready_o)
    );

    // ----------------------------------------
    // SPI controller masters, side by side
    // ----------------------------------------
    axi_wr_master u_wr (
        .clk      (clk),       .io_rst_i (io_rst_o),  .wr_req_i (spi_wr_req), .addr_i (dev_addr_i),
        .awaddr_o (awaddr_o),  .awvalid_o(awvalid_o), .awready_i(awready_i),
        .wvalid_o (wvalid_o),  .wready_i (wready_i),
        .bvalid_i (bvalid_i),  .bready_o (bready_o),  .wr_done_o(wr_done)
    );

    axi_rd_master u_rd (
        .clk      (clk),       .io_rst_i (io_rst_o),  .rd_req_i (spi_rd_req), .addr_i (dev_addr_i),
        .araddr_o (araddr_o),  .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i  (rdata_i),   .rvalid_i (rvalid_i),  .rready_o (rready_o),
        .rd_word_o(rd_word),   .rd_done_o(rd_done)
    );

endmodule
